/* filelist.f */
source/trace_pkg.sv
source/csr_view_if.sv
source/trace_capture.sv
source/trace_fifo.sv
source/trace_emitter.sv
source/core_trace_top.sv
bench/core_trace_tb.sv

/* Bender.yml */
package:
  name: core_trace

sources:
  # Design, in compile order
  - source/trace_pkg.sv
  - source/csr_view_if.sv
  - source/trace_capture.sv
  - source/trace_fifo.sv
  - source/trace_emitter.sv
  - source/core_trace_top.sv

  # Testbench
  - target: test
    files:
      - bench/core_trace_tb.sv

/* bench/core_trace_tb.sv */
`timescale 1ns/1ps

module core_trace_tb;
    import trace_pkg::*;

    // One retirement update and the idle cycles after it
    typedef struct {
        int          tst;
        logic [31:0] npc;
        logic [31:0] instr;
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
        logic [2:0]  ev;       // {exc, irq, wake}
        logic [7:0]  csrb;     // {mst_mie, mst_mpie, msie, mtie, meie, msip, mtip, meip}
        logic [31:0] mepc;
        logic [4:0]  mc;       // {irq flag, code}
        logic [31:0] mtval;
        int          gap;
    } row_t;

    // Expected trace line
    typedef struct packed {
        event_e      ev;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] npc;
        field_e      fld;
        logic [4:0]  rix;
        logic [31:0] val;
    } line_t;

    logic clk, rst_n;
    logic update_pc_en_i, rf_wr_en_i, exc_i, irq_i, wake_i;
    logic [31:0] update_pc_i, instr_i, rf_wr_data_i, mtval_i;
    logic [4:0] rf_wr_addr_i;
    logic mstatus_mie_i, mstatus_mpie_i, mie_msie_i, mie_mtie_i, mie_meie_i;
    logic mip_msip_i, mip_mtip_i, mip_meip_i, mcause_irq_i;
    logic [31:1] mepc_i;
    logic [3:0] mcause_ec_i;
    logic trace_valid_o, trace_overflow_o;
    event_e trace_event_o;
    field_e trace_field_o;
    logic [31:0] trace_pc_o, trace_instr_o, trace_npc_o, trace_value_o;
    logic [4:0] trace_reg_o;

    row_t   rows[$];
    line_t  exp_q[$];          // Lines still owed by the DUT
    int     qlen[$];           // Model FIFO, line count per entry
    string  names[6] = '{"reset", "gpr writes", "exc and irq", "wakeup",
                         "back to back", "overflow"};
    integer seed;
    int     errors, lines_chk, cycles, limit;
    bit     first_seen;

    // Model state
    logic [31:0] pc_m, npc_m, pinstr, pdata;
    logic [4:0]  paddr;
    logic        pend_m, pwe, act_m, ovf_m;
    event_e      pev;
    int          rem_m;

    core_trace_top DUT (.*);

    always #50 clk = ~clk;

    // ------------------------------
    // Table and drive helpers
    // ------------------------------
    task automatic add_row(input int t, input logic [31:0] npc, instr, input logic we,
                           input logic [4:0] addr, input logic [31:0] data,
                           input logic [2:0] ev, input logic [7:0] csrb,
                           input logic [31:0] mepc, input logic [4:0] mc,
                           input logic [31:0] mtval, input int gap);
        rows.push_back('{t, npc, instr, we, addr, data, ev, csrb, mepc, mc, mtval, gap});
    endtask

    task automatic apply_row(input row_t r);
        update_pc_en_i = 1'b1;
        update_pc_i    = r.npc;
        instr_i        = r.instr;
        rf_wr_en_i     = r.we;
        rf_wr_addr_i   = r.addr;
        rf_wr_data_i   = r.data;
        {exc_i, irq_i, wake_i} = r.ev;
        {mstatus_mie_i, mstatus_mpie_i, mie_msie_i, mie_mtie_i, mie_meie_i,
         mip_msip_i, mip_mtip_i, mip_meip_i} = r.csrb;
        mepc_i = r.mepc[31:1];
        {mcause_irq_i, mcause_ec_i} = r.mc;
        mtval_i = r.mtval;
    endtask

    task automatic go_idle();
        update_pc_en_i = 1'b0;                // CSR bits stay as they are
        rf_wr_en_i     = 1'b0;
        {exc_i, irq_i, wake_i} = 3'b000;
    endtask

    function automatic line_t make_line(field_e f, logic [4:0] r, logic [31:0] v);
        return '{pev, pc_m, pinstr, npc_m, f, r, v};
    endfunction

    // Lines of the pending entry, CSR words rebuilt from the inputs held now
    task automatic expand_entry(output int n);
        logic [31:0] mst, mie_w, mip_w, mepc_w, mc_w;
        mst = '0;
        mst[MSTATUS_MIE_BIT]  = mstatus_mie_i;
        mst[MSTATUS_MPIE_BIT] = mstatus_mpie_i;
        mst[12:11]            = 2'b11;        // Always M mode
        mie_w = '0;
        mie_w[IRQ_MSI_BIT] = mie_msie_i;
        mie_w[IRQ_MTI_BIT] = mie_mtie_i;
        mie_w[IRQ_MEI_BIT] = mie_meie_i;
        mip_w = '0;
        mip_w[IRQ_MSI_BIT] = mip_msip_i;
        mip_w[IRQ_MTI_BIT] = mip_mtip_i;
        mip_w[IRQ_MEI_BIT] = mip_meip_i;
        mepc_w = {mepc_i, 1'b0};
        mc_w   = {mcause_irq_i, 27'd0, mcause_ec_i};
        n = 1;
        case (pev)
            EV_EXC, EV_IRQ: begin
                exp_q.push_back(make_line(FLD_MSTATUS, 5'd0, mst));
                exp_q.push_back(make_line(FLD_MEPC, 5'd0, mepc_w));
                exp_q.push_back(make_line(FLD_MCAUSE, 5'd0, mc_w));
                exp_q.push_back(make_line(FLD_MTVAL, 5'd0, mtval_i));
                n = 4;
            end
            EV_WAKE: begin
                if (|(mip_w & mie_w)) begin
                    exp_q.push_back(make_line(FLD_MIP, 5'd0, mip_w));
                    exp_q.push_back(make_line(FLD_MIE, 5'd0, mie_w));
                    n = 2;
                end else begin
                    exp_q.push_back(make_line(FLD_NONE, 5'd0, 32'd0));
                end
            end
            default: begin
                if (pwe && paddr != 0) exp_q.push_back(make_line(FLD_GPR, paddr, pdata));
                else exp_q.push_back(make_line(FLD_NONE, 5'd0, 32'd0));
            end
        endcase
    endtask

    // ------------------------------
    // Reference model, one step per edge
    // ------------------------------
    always @(posedge clk) begin
        int pre_cnt, n;
        bit pop;
        if (!rst_n) begin
            pc_m = '0; npc_m = '0;
            pend_m = 0; act_m = 0; rem_m = 0; ovf_m = 0;
            qlen.delete();
        end else begin
            pre_cnt = qlen.size();
            pop = (pre_cnt > 0) && (!act_m || rem_m == 1);
            if (act_m && rem_m > 1) rem_m--;
            else if (pop && act_m) rem_m = qlen.pop_front();   // Next entry, line 0 follows
            else if (pop) begin
                n = qlen.pop_front();             // Line 0 goes out now
                rem_m = n - 1;
                act_m = (n > 1);
            end else act_m = 0;
            // Push of the entry seen one edge ago, dropped when full
            if (pend_m) begin
                if (pre_cnt < FIFO_DEPTH) begin
                    expand_entry(n);
                    qlen.push_back(n);
                end else ovf_m = 1;
            end
            pend_m = update_pc_en_i | rf_wr_en_i;
            if (pend_m) begin
                pc_m   = npc_m;
                npc_m  = update_pc_i;
                pinstr = instr_i;
                pwe    = rf_wr_en_i;
                paddr  = rf_wr_addr_i;
                pdata  = rf_wr_data_i;
                pev    = exc_i ? EV_EXC : irq_i ? EV_IRQ : wake_i ? EV_WAKE : EV_NONE;
            end
        end
    end

    // Output checks, mid cycle
    always @(negedge clk) begin
        line_t got, e;
        if (rst_n) begin
            assert (trace_overflow_o == ovf_m)
                else begin $display("FAILED %0t: overflow flag is %b", $time, trace_overflow_o);
                errors++; end
            if (trace_valid_o) begin
                assert (exp_q.size() != 0)
                    else begin $display("Trace line at %0t with nothing expected", $time);
                    errors++; end
                if (exp_q.size() != 0) begin
                    got = '{trace_event_o, trace_pc_o, trace_instr_o, trace_npc_o,
                            trace_field_o, trace_reg_o, trace_value_o};
                    e = exp_q.pop_front();
                    lines_chk++;
                    assert (got == e) else begin
                        $display("FAILED %0t: trace line mismatch", $time);
                        $display("  exp ev %0d pc %h npc %h fld %0d reg %0d val %h",
                                 e.ev, e.pc, e.npc, e.fld, e.rix, e.val);
                        $display("  got ev %0d pc %h npc %h fld %0d reg %0d val %h",
                                 got.ev, got.pc, got.npc, got.fld, got.rix, got.val);
                        errors++;
                    end
                end
                if (!first_seen) begin
                    first_seen = 1;
                    assert (trace_pc_o == '0 && trace_npc_o == rows[0].npc)
                        else begin $display("FAILED %0t: first entry pc chain", $time);
                        errors++; end
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: run went past %0d cycles", limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Drain the pipe and report one test
    task automatic finish_test(input int t, input int err0, input int ln0);
        @(posedge clk);
        #5;
        go_idle();
        while (exp_q.size() != 0 || pend_m || act_m || qlen.size() != 0) @(negedge clk);
        @(negedge clk);
        $display("test %0d %s: %0d lines, %0d errors", t, names[t],
                 lines_chk - ln0, errors - err0);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int cur, err0, ln0;
        clk = 0; rst_n = 0;
        go_idle();
        update_pc_i = '0; instr_i = '0; rf_wr_addr_i = '0; rf_wr_data_i = '0;
        {mstatus_mie_i, mstatus_mpie_i, mie_msie_i, mie_mtie_i, mie_meie_i} = '0;
        {mip_msip_i, mip_mtip_i, mip_meip_i, mcause_irq_i} = '0;
        mepc_i = '0; mcause_ec_i = '0; mtval_i = '0;
        errors = 0; lines_chk = 0; cycles = 0; first_seen = 0; limit = 1000;
        seed = 32'h170a_912c;

        add_row(0, 32'h100, 32'h00000013, 1, 5'd1, 32'h11, 3'b000, 8'h00, 0, 0, 0, 3);
        add_row(1, 32'h104, 32'h00a00093, 1, 5'd1, 32'h0a, 3'b000, 8'h00, 0, 0, 0, 2);
        add_row(1, 32'h106, 32'h00004505, 1, 5'd10, $random(seed), 3'b000, 8'h00, 0, 0, 0, 1);
        add_row(1, 32'h10a, 32'h00100013, 1, 5'd0, 32'hdead, 3'b000, 8'h00, 0, 0, 0, 2);
        add_row(1, 32'h10e, 32'h0040006f, 0, 5'd3, 32'h5, 3'b000, 8'h00, 0, 0, 0, 2);
        add_row(2, 32'h200, 32'h00000073, 0, 0, 0, 3'b100, 8'b01_000_000, 32'h10e, 5'd11, 0, 3);
        add_row(2, 32'h204, 32'h00000013, 0, 0, 0, 3'b010, 8'b01_010_010, 32'h200,
                {1'b1, 4'd7}, 0, 3);
        add_row(2, 32'h208, 32'h00002003, 0, 0, 0, 3'b110, 8'b10_000_000, 32'h204, 5'd2,
                32'hbad0_0001, 3);
        add_row(3, 32'h300, 32'h10500073, 0, 0, 0, 3'b001, 8'b10_010_010, 0, 0, 0, 2);
        add_row(3, 32'h304, 32'h10500073, 0, 0, 0, 3'b001, 8'b10_100_010, 0, 0, 0, 2);
        add_row(3, 32'h308, 32'h10500073, 0, 0, 0, 3'b011, 8'b00_001_001, 32'h304,
                {1'b1, 4'd11}, 0, 2);
        for (int i = 0; i < 5; i++)
            add_row(4, 32'h400 + 4 * i, 32'h00000013 + i, 1, 5'(i + 5), $random(seed),
                    3'b000, 8'h00, 0, 0, 0, 0);
        for (int i = 0; i < 14; i++)
            add_row(5, 32'h500 + 4 * i, 32'h00100073, 0, 0, 0, 3'b100, 8'b11_000_000,
                    32'h500 + 4 * i, 5'd3, $random(seed), 0);

        // Gaps plus four lines per row plus slack
        limit = 50;
        foreach (rows[i]) limit += rows[i].gap + 4;

        repeat (4) @(posedge clk);
        #5;
        rst_n = 1;
        repeat (3) begin
            @(negedge clk);
            assert (!trace_valid_o && !trace_overflow_o)
                else begin $display("FAILED %0t: outputs active after reset", $time);
                errors++; end
        end

        cur = rows[0].tst; err0 = errors; ln0 = lines_chk;
        foreach (rows[i]) begin
            if (rows[i].tst != cur) begin
                finish_test(cur, err0, ln0);
                cur = rows[i].tst; err0 = errors; ln0 = lines_chk;
            end
            @(posedge clk);
            #5;
            apply_row(rows[i]);
            repeat (rows[i].gap) begin
                @(posedge clk);
                #5;
                go_idle();
            end
        end
        finish_test(cur, err0, ln0);

        // Sticky after the burst
        assert (trace_overflow_o)
            else begin $display("FAILED %0t: overflow flag low after burst", $time);
            errors++; end

        $display("Summary: %0d tests, %0d lines checked, %0d errors", 6, lines_chk, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* source/core_trace_top.sv */
`timescale 1ns/1ps

module core_trace_top (
    input  logic                                clk,
    input  logic                                rst_n,
    // Retirement
    input  logic                                update_pc_en_i,
    input  logic [trace_pkg::XLEN-1:0]          update_pc_i,
    input  logic [trace_pkg::XLEN-1:0]          instr_i,
    input  logic                                rf_wr_en_i,
    input  logic [trace_pkg::REG_AW-1:0]        rf_wr_addr_i,
    input  logic [trace_pkg::XLEN-1:0]          rf_wr_data_i,
    // CSR bits
    input  logic                                mstatus_mie_i,
    input  logic                                mstatus_mpie_i,
    input  logic                                mie_msie_i,
    input  logic                                mie_mtie_i,
    input  logic                                mie_meie_i,
    input  logic                                mip_msip_i,
    input  logic                                mip_mtip_i,
    input  logic                                mip_meip_i,
    input  logic [trace_pkg::XLEN-1:1]          mepc_i,
    input  logic                                mcause_irq_i,
    input  logic [trace_pkg::EXC_CODE_W-1:0]    mcause_ec_i,
    input  logic [trace_pkg::XLEN-1:0]          mtval_i,
    // Events
    input  logic                                exc_i,
    input  logic                                irq_i,
    input  logic                                wake_i,
    // Trace lines
    output logic                                trace_valid_o,
    output trace_pkg::event_e                   trace_event_o,
    output logic [trace_pkg::XLEN-1:0]          trace_pc_o,
    output logic [trace_pkg::XLEN-1:0]          trace_instr_o,
    output logic [trace_pkg::XLEN-1:0]          trace_npc_o,
    output trace_pkg::field_e                   trace_field_o,
    output logic [trace_pkg::REG_AW-1:0]        trace_reg_o,
    output logic [trace_pkg::XLEN-1:0]          trace_value_o,
    output logic                                trace_overflow_o
);
    import trace_pkg::*;

    logic         push;
    trace_entry_t push_entry;
    trace_entry_t head;
    logic         empty;
    logic         pop;

    // CSR bundle
    csr_view_if csr_if ();

    assign csr_if.mstatus_mie  = mstatus_mie_i;
    assign csr_if.mstatus_mpie = mstatus_mpie_i;
    assign csr_if.mie_msie     = mie_msie_i;
    assign csr_if.mie_mtie     = mie_mtie_i;
    assign csr_if.mie_meie     = mie_meie_i;
    assign csr_if.mip_msip     = mip_msip_i;
    assign csr_if.mip_mtip     = mip_mtip_i;
    assign csr_if.mip_meip     = mip_meip_i;
    assign csr_if.mepc         = mepc_i;
    assign csr_if.mcause_irq   = mcause_irq_i;
    assign csr_if.mcause_ec    = mcause_ec_i;
    assign csr_if.mtval        = mtval_i;

    trace_capture u_capture (
        .clk, .rst_n,
        .update_pc_en_i, .update_pc_i, .instr_i,
        .rf_wr_en_i, .rf_wr_addr_i, .rf_wr_data_i,
        .exc_i, .irq_i, .wake_i,
        .csr          (csr_if.snap),
        .push_o       (push),
        .push_entry_o (push_entry)
    );

    trace_fifo u_fifo (
        .clk, .rst_n,
        .push_i       (push),
        .push_entry_i (push_entry),
        .pop_i        (pop),
        .head_o       (head),
        .empty_o      (empty),
        .overflow_o   (trace_overflow_o)
    );

    trace_emitter u_emitter (
        .clk, .rst_n,
        .head_i  (head),
        .empty_i (empty),
        .pop_o   (pop),
        .trace_valid_o, .trace_event_o, .trace_pc_o, .trace_instr_o,
        .trace_npc_o, .trace_field_o, .trace_reg_o, .trace_value_o
    );

endmodule

/* source/trace_emitter.sv */
`timescale 1ns/1ps

module trace_emitter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  trace_pkg::trace_entry_t      head_i,
    input  logic                         empty_i,
    output logic                         pop_o,
    output logic                         trace_valid_o,
    output trace_pkg::event_e            trace_event_o,
    output logic [trace_pkg::XLEN-1:0]   trace_pc_o,
    output logic [trace_pkg::XLEN-1:0]   trace_instr_o,
    output logic [trace_pkg::XLEN-1:0]   trace_npc_o,
    output trace_pkg::field_e            trace_field_o,
    output logic [trace_pkg::REG_AW-1:0] trace_reg_o,
    output logic [trace_pkg::XLEN-1:0]   trace_value_o
);
    import trace_pkg::*;

    logic              active_q;     // cur_q still has lines to send
    trace_entry_t      cur_q;
    logic [1:0]        idx_q;        // Next line of cur_q
    trace_entry_t      src;
    logic [1:0]        idx;
    logic [1:0]        last_idx;
    logic              wake_hit;     // Pending and enabled irq
    logic              emit;
    logic              last;
    field_e            fld;
    logic [REG_AW-1:0] rix;
    logic [XLEN-1:0]   val;

    // Idle takes line 0 straight from the head
    assign src      = active_q ? cur_q : head_i;
    assign idx      = active_q ? idx_q : 2'd0;
    assign wake_hit = |(src.csr.mip & src.csr.mie);
    assign emit     = active_q | ~empty_i;

    // ------------------------------
    // Line sequence per event
    // ------------------------------
    always_comb begin
        case (src.ev)
            EV_EXC, EV_IRQ: last_idx = 2'd3;                   // Four CSR lines
            EV_WAKE:        last_idx = wake_hit ? 2'd1 : 2'd0;
            default:        last_idx = 2'd0;
        endcase
    end

    assign last  = (idx == last_idx);
    assign pop_o = ~empty_i & (~active_q | last);   // Refill on the last line

    always_comb begin
        fld = FLD_NONE;
        rix = '0;
        val = '0;
        case (src.ev)
            EV_EXC, EV_IRQ: begin
                case (idx)
                    2'd0:    begin fld = FLD_MSTATUS; val = src.csr.mstatus; end
                    2'd1:    begin fld = FLD_MEPC;    val = src.csr.mepc;    end
                    2'd2:    begin fld = FLD_MCAUSE;  val = src.csr.mcause;  end
                    default: begin fld = FLD_MTVAL;   val = src.csr.mtval;   end
                endcase
            end
            EV_WAKE: begin
                if (wake_hit) begin
                    fld = (idx == 2'd0) ? FLD_MIP : FLD_MIE;
                    val = (idx == 2'd0) ? src.csr.mip : src.csr.mie;
                end
            end
            default: begin
                // x0 writes are not reported
                if (src.reg_wr && src.reg_addr != '0) begin
                    fld = FLD_GPR;
                    rix = src.reg_addr;
                    val = src.reg_data;
                end
            end
        endcase
    end

    // ------------------------------
    // Sequencing
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q      <= 1'b0;
            idx_q         <= '0;
            trace_valid_o <= 1'b0;
        end else begin
            trace_valid_o <= emit;
            if (active_q && !last) begin
                idx_q <= idx_q + 2'd1;
            end else if (pop_o && active_q) begin
                active_q <= 1'b1;               // Next entry, line 0 follows
                idx_q    <= 2'd0;
            end else if (pop_o) begin
                active_q <= ~last;              // Line 0 already out
                idx_q    <= 2'd1;
            end else begin
                active_q <= 1'b0;
            end
        end
    end

    // Line registers and loaded entry
    always_ff @(posedge clk) begin
        if (pop_o) cur_q <= head_i;
        if (emit) begin
            trace_event_o <= src.ev;
            trace_pc_o    <= src.pc;
            trace_instr_o <= src.instr;
            trace_npc_o   <= src.npc;
            trace_field_o <= fld;
            trace_reg_o   <= rix;
            trace_value_o <= val;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        pop_o |-> !empty_i)
        else $error("trace_emitter: pop while queue empty");

endmodule

/* source/trace_fifo.sv */
`timescale 1ns/1ps

module trace_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push_i,
    input  trace_pkg::trace_entry_t push_entry_i,
    input  logic                    pop_i,
    output trace_pkg::trace_entry_t head_o,      // Show-ahead
    output logic                    empty_o,
    output logic                    overflow_o   // Sticky until reset
);
    import trace_pkg::*;

    trace_entry_t       mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;       // Occupancy with an extra bit for full
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == FIFO_DEPTH);
    assign empty_o = (count == '0);
    assign do_push = push_i & ~full;  // Dropped when full
    assign do_pop  = pop_i & ~empty_o;

    // ------------------------------
    // Pointers and count
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Idle or both
            endcase
            if (push_i && full) overflow_o <= 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry_i;
        end
    end

    assign head_o = mem[rd_ptr];

    // ------------------------------
    // Checks
    // ------------------------------
    assert property (@(posedge clk) disable iff (!rst_n)
        count <= FIFO_DEPTH)
        else $error("trace_fifo: occupancy above depth");

    assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> !empty_o)
        else $error("trace_fifo: pop while empty");

endmodule

/* source/trace_capture.sv */
`timescale 1ns/1ps

module trace_capture (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          update_pc_en_i,  // PC retired
    input  logic [trace_pkg::XLEN-1:0]    update_pc_i,     // Next PC
    input  logic [trace_pkg::XLEN-1:0]    instr_i,
    input  logic                          rf_wr_en_i,
    input  logic [trace_pkg::REG_AW-1:0]  rf_wr_addr_i,
    input  logic [trace_pkg::XLEN-1:0]    rf_wr_data_i,
    input  logic                          exc_i,
    input  logic                          irq_i,
    input  logic                          wake_i,
    csr_view_if.snap                      csr,
    output logic                          push_o,
    output trace_pkg::trace_entry_t       push_entry_o
);
    import trace_pkg::*;

    logic              update;       // Any retirement activity
    logic [XLEN-1:0]   pc_q;
    logic [XLEN-1:0]   npc_q;
    logic [XLEN-1:0]   instr_q;
    event_e            ev_q;
    logic              reg_wr_q;
    logic [REG_AW-1:0] reg_addr_q;
    logic [XLEN-1:0]   reg_data_q;
    csr_snap_t         snap;

    assign update = update_pc_en_i | rf_wr_en_i;

    // ------------------------------
    // PC chain and event
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q     <= '0;          // First entry reports pc 0
            npc_q    <= '0;
            ev_q     <= EV_NONE;
            reg_wr_q <= 1'b0;
            push_o   <= 1'b0;
        end else begin
            push_o <= update;        // Push one cycle later, CSRs settled
            if (update) begin
                pc_q     <= npc_q;   // Old next PC becomes current
                npc_q    <= update_pc_i;
                reg_wr_q <= rf_wr_en_i;
                // Exception wins, then interrupt, then wakeup
                if (exc_i) begin
                    ev_q <= EV_EXC;
                end else if (irq_i) begin
                    ev_q <= EV_IRQ;
                end else if (wake_i) begin
                    ev_q <= EV_WAKE;
                end else begin
                    ev_q <= EV_NONE;
                end
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (update) begin
            instr_q <= instr_i;
            if (rf_wr_en_i) begin
                reg_addr_q <= rf_wr_addr_i;
                reg_data_q <= rf_wr_data_i;
            end
        end
    end

    // ------------------------------
    // CSR words
    // ------------------------------
    always_comb begin
        snap = '0;
        snap.mstatus[MSTATUS_MIE_BIT]              = csr.mstatus_mie;
        snap.mstatus[MSTATUS_MPIE_BIT]             = csr.mstatus_mpie;
        snap.mstatus[MSTATUS_MPP_LSB+1:MSTATUS_MPP_LSB] = MSTATUS_MPP_M;

        snap.mie[IRQ_MSI_BIT] = csr.mie_msie;
        snap.mie[IRQ_MTI_BIT] = csr.mie_mtie;
        snap.mie[IRQ_MEI_BIT] = csr.mie_meie;
        snap.mip[IRQ_MSI_BIT] = csr.mip_msip;
        snap.mip[IRQ_MTI_BIT] = csr.mip_mtip;
        snap.mip[IRQ_MEI_BIT] = csr.mip_meip;

        snap.mepc = {csr.mepc, 1'b0};             // Halfword aligned
        snap.mcause[XLEN-1]         = csr.mcause_irq;  // Interrupt flag on top
        snap.mcause[EXC_CODE_W-1:0] = csr.mcause_ec;
        snap.mtval = csr.mtval;
    end

    // Entry for the queue, CSRs taken in the push cycle
    assign push_entry_o = '{
        ev:       ev_q,
        pc:       pc_q,
        instr:    instr_q,
        npc:      npc_q,
        reg_wr:   reg_wr_q,
        reg_addr: reg_addr_q,
        reg_data: reg_data_q,
        csr:      snap
    };

    // A retirement must come with clean event strobes
    assert property (@(posedge clk) disable iff (!rst_n)
        update |-> !$isunknown({exc_i, irq_i, wake_i}))
        else $error("trace_capture: unknown event strobe on update");

endmodule

/* source/csr_view_if.sv */
`timescale 1ns/1ps

// Machine-mode CSR bits as the core exports them
interface csr_view_if;
    import trace_pkg::*;

    logic                  mstatus_mie;
    logic                  mstatus_mpie;
    logic                  mie_msie;          // Enables
    logic                  mie_mtie;
    logic                  mie_meie;
    logic                  mip_msip;          // Pending
    logic                  mip_mtip;
    logic                  mip_meip;
    logic [XLEN-1:1]       mepc;              // Bit 0 always zero with RVC
    logic                  mcause_irq;
    logic [EXC_CODE_W-1:0] mcause_ec;
    logic [XLEN-1:0]       mtval;

    // Driven from top-level ports
    modport src (
        output mstatus_mie, mstatus_mpie, mie_msie, mie_mtie, mie_meie,
               mip_msip, mip_mtip, mip_meip, mepc, mcause_irq, mcause_ec, mtval
    );

    // Sampled by capture
    modport snap (
        input  mstatus_mie, mstatus_mpie, mie_msie, mie_mtie, mie_meie,
               mip_msip, mip_mtip, mip_meip, mepc, mcause_irq, mcause_ec, mtval
    );

endinterface

/* source/trace_pkg.sv */
package trace_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int XLEN       = 32;               // Data and PC width
    localparam int REG_AW     = 5;                // x0..x31
    localparam int FIFO_DEPTH = 8;                // Queued entries
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int EXC_CODE_W = 4;                // mcause code width

    // ------------------------------
    // CSR bit positions
    // ------------------------------
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;         // Two-bit MPP field
    localparam logic [1:0] MSTATUS_MPP_M = 2'b11; // Machine mode only

    // Shared by mie and mip
    localparam int IRQ_MSI_BIT = 3;
    localparam int IRQ_MTI_BIT = 7;
    localparam int IRQ_MEI_BIT = 11;

    // ------------------------------
    // Codes
    // ------------------------------
    typedef enum logic [1:0] {
        EV_NONE = 2'd0,                           // Plain retirement
        EV_EXC  = 2'd1,
        EV_IRQ  = 2'd2,
        EV_WAKE = 2'd3
    } event_e;

    // What a trace line reports
    typedef enum logic [2:0] {
        FLD_NONE    = 3'd0,
        FLD_GPR     = 3'd1,
        FLD_MSTATUS = 3'd2,
        FLD_MEPC    = 3'd3,
        FLD_MCAUSE  = 3'd4,
        FLD_MTVAL   = 3'd5,
        FLD_MIP     = 3'd6,
        FLD_MIE     = 3'd7
    } field_e;

    // ------------------------------
    // Entry layout
    // ------------------------------
    // Full CSR words, rebuilt from the core's bits
    typedef struct packed {
        logic [XLEN-1:0] mstatus;
        logic [XLEN-1:0] mie;
        logic [XLEN-1:0] mip;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
    } csr_snap_t;

    // One retirement update
    typedef struct packed {
        event_e            ev;
        logic [XLEN-1:0]   pc;                    // Retired PC
        logic [XLEN-1:0]   instr;
        logic [XLEN-1:0]   npc;                   // Next PC
        logic              reg_wr;                // GPR write seen
        logic [REG_AW-1:0] reg_addr;
        logic [XLEN-1:0]   reg_data;
        csr_snap_t         csr;
    } trace_entry_t;

endpackage
